// File: Bender.yml
package:
  name: cpu8

export_include_dirs:
  - hw

sources:
  - hw/cpu8Pkg.sv
  - hw/pipeStage.sv
  - hw/instrDecode.sv
  - hw/aluExecute.sv
  - hw/resultWriter.sv
  - hw/cpu8Top.sv
  - target: test
    files:
      - test/cpu8_sva.sv
      - test/cpu8Tb.sv

// File: hw/aluExecute.sv
`timescale 1ns/1ps
`include "cpu8_settings.svh"

module aluExecute (
    input  logic                opValid,
    output logic                opReady,
    input  cpu8Pkg::execOpT     op,
    output logic                resValid,
    input  logic                resReady,
    output cpu8Pkg::execResultT res
);
    localparam int DataW = `CPU8_DATA_WIDTH;
    localparam int Msb   = DataW - 1;

    logic [DataW-1:0]   a;
    logic [DataW-1:0]   b;
    logic [DataW:0]     sum;                     // Carry in the top bit
    logic [DataW-1:0]   diff;
    logic [2*DataW-1:0] prod;
    logic               divByZero;
    logic               divOp;
    logic               signOp;
    logic [DataW-1:0]   value;
    cpu8Pkg::flagsT     flags;

    assign a         = op.operandA;
    assign b         = op.operandB;
    assign sum       = {1'b0, a} + {1'b0, b};
    assign diff      = a - b;
    assign prod      = a * b;                    // Full 16-bit product
    assign divByZero = (b == '0);
    assign divOp     = (op.aluOp == cpu8Pkg::aluDiv) || (op.aluOp == cpu8Pkg::aluMod);
    // Sign only for add, sub and the logic ops
    assign signOp    = !divOp && (op.aluOp != cpu8Pkg::aluMul) &&
                       (op.aluOp != cpu8Pkg::aluCmp);

    always_comb begin
        value = '0;
        flags = '0;
        case (op.aluOp)
            cpu8Pkg::aluAdd: begin
                value          = sum[DataW-1:0];
                flags.carry    = sum[DataW];
                flags.overflow = (a[Msb] == b[Msb]) && (value[Msb] != a[Msb]);
            end
            cpu8Pkg::aluSub: begin
                value          = diff;
                flags.carry    = (a < b);        // Borrow
                flags.overflow = (a[Msb] != b[Msb]) && (value[Msb] != a[Msb]);
            end
            cpu8Pkg::aluMul: begin
                value          = prod[DataW-1:0];
                flags.overflow = |prod[2*DataW-1:DataW];
            end
            cpu8Pkg::aluDiv:  value = divByZero ? '1 : a / b;
            cpu8Pkg::aluMod:  value = divByZero ? '1 : a % b;
            cpu8Pkg::aluCmp:  flags.overflow = (a == b); // Value stays 0
            cpu8Pkg::aluAnd:  value = a & b;
            cpu8Pkg::aluOr:   value = a | b;
            cpu8Pkg::aluNot:  value = ~a;
            cpu8Pkg::aluXor:  value = a ^ b;
            cpu8Pkg::aluNand: value = ~(a & b);
            cpu8Pkg::aluNor:  value = ~(a | b);
            cpu8Pkg::aluXnor: value = ~(a ^ b);
            default: begin
            end
        endcase
        if (op.aluOp != cpu8Pkg::aluCmp) begin
            flags.zero   = (value == '0);
            flags.parity = ^value;
        end
        if (signOp) begin
            flags.sign = value[Msb];
        end
        if (divOp && divByZero) begin
            flags = '1;                          // Error result, every flag set
        end
    end

    assign res.value = value;
    assign res.flags = flags;
    assign resValid  = opValid;                  // Handshake passes straight through
    assign opReady   = resReady;
endmodule

// File: hw/cpu8Pkg.sv
`include "cpu8_settings.svh"

package cpu8Pkg;

    typedef enum logic [3:0] {
        aluAdd  = 4'h0,
        aluSub  = 4'h1,
        aluMul  = 4'h2,
        aluDiv  = 4'h3,
        aluMod  = 4'h4,
        aluCmp  = 4'h5,
        aluAnd  = 4'h6,
        aluOr   = 4'h7,
        aluNot  = 4'h8,
        aluXor  = 4'h9,
        aluNand = 4'hA,
        aluNor  = 4'hB,
        aluXnor = 4'hC
    } aluOpE;

    // Flags as written to bits 12:8 of an answer word
    typedef struct packed {
        logic sign;                              // Result MSB
        logic carry;                             // Add carry out, sub borrow
        logic zero;                              // Result is zero
        logic parity;                            // XOR of result bits
        logic overflow;                          // Signed/mul overflow, cmp equality
    } flagsT;

    typedef struct packed {
        aluOpE                       aluOp;
        logic [`CPU8_DATA_WIDTH-1:0] operandA;
        logic [`CPU8_DATA_WIDTH-1:0] operandB;
    } execOpT;

    typedef struct packed {
        logic [`CPU8_DATA_WIDTH-1:0] value;
        flagsT                       flags;
    } execResultT;

    typedef struct packed {
        logic                            arValid;
        logic [`CPU8_AXI_ADDR_WIDTH-1:0] arAddr;
        logic                            rReady;
    } axiReadOutT;

    typedef struct packed {
        logic                            arReady;
        logic                            rValid;
        logic [`CPU8_AXI_DATA_WIDTH-1:0] rData;
        logic [1:0]                      rResp;
    } axiReadInT;

    typedef struct packed {
        logic                              awValid;
        logic [`CPU8_AXI_ADDR_WIDTH-1:0]   awAddr;
        logic                              wValid;
        logic [`CPU8_AXI_DATA_WIDTH-1:0]   wData;
        logic [`CPU8_AXI_DATA_WIDTH/8-1:0] wStrb;
        logic                              bReady;
    } axiWriteOutT;

    typedef struct packed {
        logic       awReady;
        logic       wReady;
        logic       bValid;
        logic [1:0] bResp;
    } axiWriteInT;

endpackage

// File: hw/cpu8Top.sv
`timescale 1ns/1ps

module cpu8Top (
    input  logic                 clock,
    input  logic                 reset,
    output cpu8Pkg::axiReadOutT  readOut,
    input  cpu8Pkg::axiReadInT   readIn,
    output cpu8Pkg::axiWriteOutT writeOut,
    input  cpu8Pkg::axiWriteInT  writeIn,
    output logic                 done
);
    logic                opValid;
    logic                opReady;
    cpu8Pkg::execOpT     op;
    logic                stagedOpValid;
    logic                stagedOpReady;
    cpu8Pkg::execOpT     stagedOp;
    logic                resValid;
    logic                resReady;
    cpu8Pkg::execResultT res;
    logic                stagedResValid;
    logic                stagedResReady;
    cpu8Pkg::execResultT stagedRes;
    logic                halted;
    logic                writerIdle;

    instrDecode u_instrDecode (
        .clock   (clock),
        .reset   (reset),
        .readOut (readOut),
        .readIn  (readIn),
        .opValid (opValid),
        .opReady (opReady),
        .op      (op),
        .halted  (halted)
    );

    pipeStage #(.payloadT(cpu8Pkg::execOpT)) u_opStage (
        .clock    (clock),
        .reset    (reset),
        .inValid  (opValid),
        .inReady  (opReady),
        .inData   (op),
        .outValid (stagedOpValid),
        .outReady (stagedOpReady),
        .outData  (stagedOp)
    );

    aluExecute u_aluExecute (
        .opValid  (stagedOpValid),
        .opReady  (stagedOpReady),
        .op       (stagedOp),
        .resValid (resValid),
        .resReady (resReady),
        .res      (res)
    );

    pipeStage #(.payloadT(cpu8Pkg::execResultT)) u_resStage (
        .clock    (clock),
        .reset    (reset),
        .inValid  (resValid),
        .inReady  (resReady),
        .inData   (res),
        .outValid (stagedResValid),
        .outReady (stagedResReady),
        .outData  (stagedRes)
    );

    resultWriter u_resultWriter (
        .clock    (clock),
        .reset    (reset),
        .resValid (stagedResValid),
        .resReady (stagedResReady),
        .res      (stagedRes),
        .writeOut (writeOut),
        .writeIn  (writeIn),
        .idle     (writerIdle)
    );

    // Stages must be empty too, the writer goes idle between results
    assign done = halted && writerIdle && !stagedOpValid && !stagedResValid;
endmodule

// File: hw/cpu8_settings.svh
`ifndef CPU8_SETTINGS_SVH
`define CPU8_SETTINGS_SVH

`define CPU8_DATA_WIDTH     8         // Operand and result width
`define CPU8_AXI_ADDR_WIDTH 32        // AXI4-Lite address width
`define CPU8_AXI_DATA_WIDTH 32        // AXI4-Lite data width

// Address of answer slot 0, slots are 4 bytes apart
`define CPU8_ANSWER_BASE    32'h1000

// Opcodes the decoder treats specially
`define CPU8_OP_END 8'h00             // Stop fetching
`define CPU8_OP_INC 8'h01             // A + 1
`define CPU8_OP_DEC 8'h02             // A - 1
`define CPU8_OP_NOT 8'h03             // ~A
`define CPU8_OP_JMP 8'h04             // PC += B

// Two-operand opcodes are 8'h10 through 8'hC0 in steps of 8'h10
// add sub mul div mod and or xor nand nor xnor cmp

`endif

// File: hw/instrDecode.sv
`timescale 1ns/1ps
`include "cpu8_settings.svh"

module instrDecode (
    input  logic                clock,
    input  logic                reset,
    output cpu8Pkg::axiReadOutT readOut,
    input  cpu8Pkg::axiReadInT  readIn,
    output logic                opValid,
    input  logic                opReady,
    output cpu8Pkg::execOpT     op,
    output logic                halted
);
    localparam int AddrW = `CPU8_AXI_ADDR_WIDTH;
    localparam int DataW = `CPU8_DATA_WIDTH;

    typedef enum logic [2:0] {
        stOpcode,                                // Fetch instruction byte
        stOperandA,                              // Fetch first operand
        stOperandB,                              // Fetch second operand or jump length
        stIssue,                                 // Hold op until the stage takes it
        stHalted                                 // End opcode seen
    } stateE;

    stateE            state;
    logic             arValidQ;                  // AR phase of the current byte
    logic             rReadyQ;                   // R phase of the current byte
    logic [AddrW-1:0] pc;
    logic [DataW-1:0] opcodeQ;
    logic [DataW-1:0] operandAQ;
    logic [DataW-1:0] operandBQ;
    cpu8Pkg::aluOpE   aluOpQ;
    logic [DataW-1:0] fetchByte;
    logic             fetching;
    logic             byteDone;
    logic             unary;
    logic             opKnown;
    cpu8Pkg::aluOpE   byteOp;

    assign fetching  = (state == stOpcode) || (state == stOperandA) ||
                       (state == stOperandB);
    assign fetchByte = readIn.rData[DataW-1:0];  // Program byte sits in lane 0
    assign byteDone  = rReadyQ && readIn.rValid;
    assign unary     = (opcodeQ == `CPU8_OP_INC) || (opcodeQ == `CPU8_OP_DEC) ||
                       (opcodeQ == `CPU8_OP_NOT);

    // Opcode byte to ALU operation
    always_comb begin
        byteOp  = cpu8Pkg::aluAdd;
        opKnown = 1'b1;
        case (fetchByte)
            `CPU8_OP_INC: byteOp = cpu8Pkg::aluAdd;
            `CPU8_OP_DEC: byteOp = cpu8Pkg::aluSub;
            `CPU8_OP_NOT: byteOp = cpu8Pkg::aluNot;
            8'h10:        byteOp = cpu8Pkg::aluAdd;
            8'h20:        byteOp = cpu8Pkg::aluSub;
            8'h30:        byteOp = cpu8Pkg::aluMul;
            8'h40:        byteOp = cpu8Pkg::aluDiv;
            8'h50:        byteOp = cpu8Pkg::aluMod;
            8'h60:        byteOp = cpu8Pkg::aluAnd;
            8'h70:        byteOp = cpu8Pkg::aluOr;
            8'h80:        byteOp = cpu8Pkg::aluXor;
            8'h90:        byteOp = cpu8Pkg::aluNand;
            8'hA0:        byteOp = cpu8Pkg::aluNor;
            8'hB0:        byteOp = cpu8Pkg::aluXnor;
            8'hC0:        byteOp = cpu8Pkg::aluCmp;
            default:      opKnown = 1'b0;        // End, jump and unknown bytes
        endcase
    end

    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            state    <= stOpcode;
            arValidQ <= 1'b0;
            rReadyQ  <= 1'b0;
            pc       <= '0;
            opcodeQ  <= '0;
        end else begin
            if (fetching && !arValidQ && !rReadyQ) begin
                arValidQ <= 1'b1;                // Launch read at PC
            end
            if (arValidQ && readIn.arReady) begin
                arValidQ <= 1'b0;
                rReadyQ  <= 1'b1;
            end
            if (byteDone) begin
                rReadyQ <= 1'b0;
                pc      <= pc + 1'b1;
                case (state)
                    stOpcode: begin
                        opcodeQ <= fetchByte;
                        if (fetchByte == `CPU8_OP_END) begin
                            state <= stHalted;
                        end else if (fetchByte == `CPU8_OP_JMP) begin
                            state <= stOperandB; // Jump length only
                        end else if (opKnown) begin
                            state <= stOperandA;
                        end                      // Unknown byte skipped
                    end
                    stOperandA: begin
                        state <= unary ? stIssue : stOperandB;
                    end
                    stOperandB: begin
                        if (opcodeQ == `CPU8_OP_JMP) begin
                            // Relative to the byte after the length
                            pc    <= pc + AddrW'(fetchByte) + 1'b1;
                            state <= stOpcode;
                        end else begin
                            state <= stIssue;
                        end
                    end
                    default: begin
                    end
                endcase
            end
            if ((state == stIssue) && opReady) begin
                state <= stOpcode;
            end
        end
    end

    // Operation fields
    always_ff @(posedge clock) begin
        if (byteDone) begin
            case (state)
                stOpcode: aluOpQ <= byteOp;
                stOperandA: begin
                    operandAQ <= fetchByte;
                    // Inc and dec use 1, NOT ignores B
                    operandBQ <= (opcodeQ == `CPU8_OP_NOT) ? DataW'(0) : DataW'(1);
                end
                stOperandB: operandBQ <= fetchByte;
                default: begin
                end
            endcase
        end
    end

    assign readOut.arValid = arValidQ;
    assign readOut.arAddr  = pc;                 // Stable until R completes
    assign readOut.rReady  = rReadyQ;

    assign opValid     = (state == stIssue);
    assign op.aluOp    = aluOpQ;
    assign op.operandA = operandAQ;
    assign op.operandB = operandBQ;
    assign halted      = (state == stHalted);
endmodule

// File: hw/pipeStage.sv
`timescale 1ns/1ps

module pipeStage #(
    parameter type payloadT = logic
) (
    input  logic    clock,
    input  logic    reset,
    input  logic    inValid,
    output logic    inReady,
    input  payloadT inData,
    output logic    outValid,
    input  logic    outReady,
    output payloadT outData
);
    logic    full;                               // Entry holds a payload
    payloadT dataQ;

    assign inReady  = !full || outReady;         // Empty, or draining this cycle
    assign outValid = full;
    assign outData  = dataQ;

    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            full <= 1'b0;
        end else if (inValid && inReady) begin
            full <= 1'b1;                        // Refill wins over drain
        end else if (outReady) begin
            full <= 1'b0;
        end
    end

    always_ff @(posedge clock) begin
        if (inValid && inReady) begin
            dataQ <= inData;
        end
    end
endmodule

// File: hw/resultWriter.sv
`timescale 1ns/1ps
`include "cpu8_settings.svh"

module resultWriter (
    input  logic                 clock,
    input  logic                 reset,
    input  logic                 resValid,
    output logic                 resReady,
    input  cpu8Pkg::execResultT  res,
    output cpu8Pkg::axiWriteOutT writeOut,
    input  cpu8Pkg::axiWriteInT  writeIn,
    output logic                 idle
);
    localparam int AddrW = `CPU8_AXI_ADDR_WIDTH;
    localparam int BusW  = `CPU8_AXI_DATA_WIDTH;
    localparam int ValW  = `CPU8_DATA_WIDTH;
    localparam int FlagW = $bits(cpu8Pkg::flagsT);

    logic                awValidQ;
    logic                wValidQ;
    logic                bReadyQ;
    logic                awLeft;                 // AW still open after this edge
    logic                wLeft;                  // W still open after this edge
    logic [AddrW-3:0]    answerIdx;              // Slot counter, word granular
    cpu8Pkg::execResultT resQ;

    assign idle     = !(awValidQ || wValidQ || bReadyQ);
    assign resReady = idle;                      // One write at a time
    assign awLeft   = awValidQ && !writeIn.awReady;
    assign wLeft    = wValidQ && !writeIn.wReady;

    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            awValidQ  <= 1'b0;
            wValidQ   <= 1'b0;
            bReadyQ   <= 1'b0;
            answerIdx <= '0;
        end else if (resValid && resReady) begin
            awValidQ <= 1'b1;                    // AW and W rise together
            wValidQ  <= 1'b1;
        end else begin
            awValidQ <= awLeft;
            wValidQ  <= wLeft;
            if ((awValidQ || wValidQ) && !awLeft && !wLeft) begin
                bReadyQ <= 1'b1;                 // Both halves accepted
            end
            if (bReadyQ && writeIn.bValid) begin
                bReadyQ   <= 1'b0;
                answerIdx <= answerIdx + 1'b1;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (resValid && resReady) begin
            resQ <= res;
        end
    end

    assign writeOut.awValid = awValidQ;
    assign writeOut.awAddr  = `CPU8_ANSWER_BASE + {answerIdx, 2'b00};
    assign writeOut.wValid  = wValidQ;
    // Value in 7:0, flags in 12:8
    assign writeOut.wData   = {{(BusW - FlagW - ValW){1'b0}}, resQ.flags, resQ.value};
    assign writeOut.wStrb   = '1;
    assign writeOut.bReady  = bReadyQ;
endmodule

// File: tb.f
+incdir+hw
hw/cpu8Pkg.sv
hw/pipeStage.sv
hw/instrDecode.sv
hw/aluExecute.sv
hw/resultWriter.sv
hw/cpu8Top.sv
test/cpu8_sva.sv
test/cpu8Tb.sv

// File: test/cpu8Tb.sv
`timescale 1ns/1ps
`include "cpu8_settings.svh"

module cpu8Tb;
    localparam int DoneTimeout = 20000;          // Cycles allowed per program
    localparam int DrainCycles = 20;             // Watch window after done

    logic                 clock;
    logic                 reset;
    cpu8Pkg::axiReadOutT  readOut;
    cpu8Pkg::axiReadInT   readIn;
    cpu8Pkg::axiWriteOutT writeOut;
    cpu8Pkg::axiWriteInT  writeIn;
    logic                 done;

    logic [7:0]  prog[$];                        // Program memory, index is byte address
    logic [12:0] expectQ[$];                     // Predicted {flags, value} per answer
    logic [31:0] seenAddrQ[$];                   // Writes accepted by the memory model
    logic [31:0] seenDataQ[$];
    int          expectCount = 0;
    int          writeCount  = 0;
    int          errorCount  = 0;
    int          testCount   = 0;
    int          failedTests = 0;
    bit          timedOut    = 1'b0;

    // Memory model state
    logic        rBusy   = 1'b0;                 // Read accepted, data not yet taken
    int          rWait   = 0;
    logic [31:0] rWordQ  = '0;
    logic        awGot   = 1'b0;
    logic        wGot    = 1'b0;
    logic        bBusy   = 1'b0;
    int          bWait   = 0;
    logic [31:0] awAddrQ = '0;
    logic [31:0] wDataQ  = '0;

    // Compare process state
    logic [31:0] gotAddr;
    logic [31:0] gotData;
    logic [31:0] expAddr;
    logic [31:0] expData;

    cpu8Top u_cpu8Top (
        .clock    (clock),
        .reset    (reset),
        .readOut  (readOut),
        .readIn   (readIn),
        .writeOut (writeOut),
        .writeIn  (writeIn),
        .done     (done)
    );

    initial begin
        clock = 1'b0;
        forever #2 clock = ~clock;               // 4 ns period
    end

    // Expected {sign, carry, zero, parity, overflow, value} of one operation
    function automatic logic [12:0] refAlu(input logic [7:0] opc, input logic [7:0] a,
                                           input logic [7:0] b);
        logic [15:0] wide;
        logic [7:0]  v;
        logic        c;
        logic        o;
        logic        hasSign;
        int          sRes;
        v       = 8'h00;
        c       = 1'b0;
        o       = 1'b0;
        hasSign = 1'b1;
        wide    = 16'(a) * 16'(b);
        case (opc)
            `CPU8_OP_INC, 8'h10: begin
                sRes   = int'($signed(a)) + int'($signed(b));
                {c, v} = 9'(a) + 9'(b);          // Carry out of bit 7
                o      = (sRes > 127) || (sRes < -128);
            end
            `CPU8_OP_DEC, 8'h20: begin
                sRes = int'($signed(a)) - int'($signed(b));
                v    = a - b;
                c    = (a < b);
                o    = (sRes > 127) || (sRes < -128);
            end
            8'h30: begin
                v       = wide[7:0];
                o       = (wide[15:8] != 8'h00); // Product lost its high byte
                hasSign = 1'b0;
            end
            8'h40, 8'h50: begin
                if (b == 8'h00) begin
                    return 13'h1FFF;             // Divide error result
                end
                v       = (opc == 8'h40) ? a / b : a % b;
                hasSign = 1'b0;
            end
            8'hC0: return {4'b0000, a == b, 8'h00};
            8'h60: v = a & b;
            8'h70: v = a | b;
            8'h80: v = a ^ b;
            8'h90: v = ~(a & b);
            8'hA0: v = ~(a | b);
            8'hB0: v = ~(a ^ b);
            `CPU8_OP_NOT: v = ~a;
            default: begin
            end
        endcase
        return {hasSign & v[7], c, v == 8'h00, ^v, o, v};
    endfunction

    function automatic logic [7:0] randomBinaryOp();
        return 8'(16 * $urandom_range(1, 12));   // 0x10 through 0xC0
    endfunction

    task automatic emitBinary(input logic [7:0] opc, input logic [7:0] a, input logic [7:0] b);
        prog.push_back(opc);
        prog.push_back(a);
        prog.push_back(b);
    endtask

    task automatic emitUnary(input logic [7:0] opc, input logic [7:0] a);
        prog.push_back(opc);
        prog.push_back(a);
    endtask

    // Jump over n random bytes, which may look like instructions
    task automatic emitJump(input int n);
        int i;
        prog.push_back(`CPU8_OP_JMP);
        prog.push_back(8'(n));
        for (i = 0; i < n; i++) begin
            prog.push_back(8'($urandom()));
        end
    endtask

    // Walk the program as the decoder would and queue the answers
    task automatic predictAnswers();
        int         pc;
        logic [7:0] opc;
        expectQ.delete();
        pc = 0;
        while ((pc < prog.size()) && (prog[pc] != `CPU8_OP_END)) begin
            opc = prog[pc];
            if (opc == `CPU8_OP_JMP) begin
                pc += 2 + int'(prog[pc+1]);
            end else if (opc inside {`CPU8_OP_INC, `CPU8_OP_DEC, `CPU8_OP_NOT}) begin
                expectQ.push_back(refAlu(opc, prog[pc+1], 8'(opc != `CPU8_OP_NOT)));
                pc += 2;
            end else if ((opc[3:0] == 4'h0) && (opc >= 8'h10) && (opc <= 8'hC0)) begin
                expectQ.push_back(refAlu(opc, prog[pc+1], prog[pc+2]));
                pc += 3;
            end else begin
                pc += 1;                         // Unknown byte
            end
        end
        expectCount = expectQ.size();
    endtask

    task automatic resetDut();
        @(posedge clock);
        #1;
        reset = 1'b0;
        seenAddrQ.delete();
        seenDataQ.delete();
        writeCount = 0;
        repeat (3) @(posedge clock);
        #1;
        reset = 1'b1;
    endtask

    task automatic runProgram(input string name);
        int errorsBefore;
        int cycles;
        if (timedOut) begin
            return;
        end
        errorsBefore = errorCount;
        prog.push_back(`CPU8_OP_END);
        predictAnswers();
        resetDut();
        cycles = 0;
        while (!done && (cycles < DoneTimeout)) begin
            @(posedge clock);
            #1;
            cycles++;
        end
        if (!done) begin
            $display("Test %s timed out after %0d cycles waiting for done", name, cycles);
            timedOut = 1'b1;
            errorCount++;
        end else begin
            if (writeCount != expectCount) begin
                $display("[ERROR] %0t: done with %0d answers written, expected %0d",
                         $time, writeCount, expectCount);
                errorCount++;
            end
            repeat (DrainCycles) @(posedge clock); // Stray reads or writes show up here
        end
        testCount++;
        if (errorCount != errorsBefore) begin
            failedTests++;
        end
        $display("Test %-10s %3d answers, %0d errors", name, expectCount,
                 errorCount - errorsBefore);
        prog.delete();
    endtask

    // AXI memory model, samples at the edge and drives 1 ns later
    always @(posedge clock) begin
        if (!reset) begin
            rBusy = 1'b0;
            rWait = 0;
            awGot = 1'b0;
            wGot  = 1'b0;
            bBusy = 1'b0;
            bWait = 0;
        end else begin
            if (readIn.rValid && readOut.rReady) begin
                rBusy = 1'b0;
            end
            if (readOut.arValid && readIn.arReady) begin
                if (done) begin
                    $display("[ERROR] %0t: read at %h after done", $time, readOut.arAddr);
                    errorCount++;
                end
                rBusy  = 1'b1;
                rWait  = $urandom_range(0, 3);
                rWordQ = $urandom();             // Upper lanes carry noise
                if (readOut.arAddr < prog.size()) begin
                    rWordQ[7:0] = prog[readOut.arAddr];
                end else begin
                    $display("[ERROR] %0t: read at %h outside the program", $time,
                             readOut.arAddr);
                    errorCount++;
                end
            end
            if (writeOut.awValid && writeIn.awReady) begin
                awGot   = 1'b1;
                awAddrQ = writeOut.awAddr;
            end
            if (writeOut.wValid && writeIn.wReady) begin
                wGot   = 1'b1;
                wDataQ = writeOut.wData;
                if (writeOut.wStrb != 4'hF) begin
                    $display("[ERROR] %0t: wStrb %h, expected f", $time, writeOut.wStrb);
                    errorCount++;
                end
            end
            if (awGot && wGot && !bBusy) begin
                bBusy = 1'b1;                    // Both halves in, queue for compare
                bWait = $urandom_range(0, 4);
                seenAddrQ.push_back(awAddrQ);
                seenDataQ.push_back(wDataQ);
            end
            if (writeIn.bValid && writeOut.bReady) begin
                bBusy = 1'b0;
                awGot = 1'b0;
                wGot  = 1'b0;
            end
        end
        #1;
        readIn.arReady  = ($urandom_range(0, 2) != 0);
        readIn.rValid   = rBusy && (rWait == 0);
        readIn.rData    = rWordQ;
        writeIn.awReady = !awGot && ($urandom_range(0, 2) != 0);
        writeIn.wReady  = !wGot && ($urandom_range(0, 2) != 0);
        writeIn.bValid  = bBusy && (bWait == 0);
        if (rWait > 0) begin
            rWait--;
        end
        if (bWait > 0) begin
            bWait--;
        end
    end

    // Compare each accepted write against the next predicted answer
    always @(negedge clock) begin
        while (seenAddrQ.size() > 0) begin
            gotAddr = seenAddrQ.pop_front();
            gotData = seenDataQ.pop_front();
            if (expectQ.size() == 0) begin
                $display("[ERROR] %0t: unexpected write of %h to %h", $time, gotData, gotAddr);
                errorCount++;
            end else begin
                expAddr = `CPU8_ANSWER_BASE + 32'(4 * writeCount);
                expData = {19'h0, expectQ.pop_front()};
                if (gotAddr !== expAddr) begin
                    $display("[ERROR] %0t: answer %0d at %h, expected %h", $time,
                             writeCount, gotAddr, expAddr);
                    errorCount++;
                end
                if (gotData !== expData) begin
                    $display("[ERROR] %0t: answer %0d data %h, expected %h", $time,
                             writeCount, gotData, expData);
                    errorCount++;
                end
            end
            writeCount++;
        end
    end

    initial begin
        int         k;
        int         choice;
        logic [7:0] edgeVals [4];
        void'($urandom(32'h9e43));
        edgeVals = '{8'h00, 8'h7F, 8'h80, 8'hFF};
        reset    = 1'b1;
        readIn   = '0;
        writeIn  = '0;

        for (k = 0; k < 48; k++) begin           // Every binary opcode four times
            emitBinary(8'(16 * (k % 12 + 1)), 8'($urandom()), 8'($urandom()));
        end
        runProgram("binary");

        for (k = 0; k < 4; k++) begin            // Wrap and sign edges first
            emitUnary(`CPU8_OP_INC, edgeVals[k]);
            emitUnary(`CPU8_OP_DEC, edgeVals[k]);
            emitUnary(`CPU8_OP_NOT, edgeVals[k]);
        end
        for (k = 0; k < 20; k++) begin
            emitUnary(8'($urandom_range(1, 3)), 8'($urandom()));
        end
        runProgram("unary");

        for (k = 0; k < 6; k++) begin
            emitBinary(8'h40, 8'($urandom()), 8'h00);
            emitBinary(8'h50, 8'($urandom()), 8'h00);
            emitBinary(8'h40, 8'($urandom()), 8'($urandom_range(1, 255)));
        end
        runProgram("divZero");

        for (k = 0; k < 14; k++) begin
            emitBinary(randomBinaryOp(), 8'($urandom()), 8'($urandom()));
            emitJump(k % 7);                     // Zero length included
        end
        runProgram("jumps");

        for (k = 0; k < 60; k++) begin
            choice = $urandom_range(0, 5);
            if (choice < 3) begin
                emitBinary(randomBinaryOp(), 8'($urandom()), 8'($urandom()));
            end else if (choice == 3) begin
                emitUnary(8'($urandom_range(1, 3)), 8'($urandom()));
            end else if (choice == 4) begin
                emitJump($urandom_range(0, 6));
            end else begin
                prog.push_back(8'($urandom_range(5, 15))); // Undefined opcode
            end
        end
        runProgram("mixed");

        $display("Tests run %0d, tests with errors %0d, errors %0d",
                 testCount, failedTests, errorCount);
        if ((errorCount == 0) && !timedOut) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end
endmodule

// File: test/cpu8_sva.sv
`timescale 1ns/1ps

module cpu8Sva (
    input logic                 clock,
    input logic                 reset,
    input cpu8Pkg::axiReadOutT  readOut,
    input cpu8Pkg::axiReadInT   readIn,
    input cpu8Pkg::axiWriteOutT writeOut,
    input cpu8Pkg::axiWriteInT  writeIn,
    input logic [1:0]           stageValid,
    input logic                 done
);
    // AR held with a stable address until accepted
    arStable: assert property (@(posedge clock) disable iff (!reset)
        readOut.arValid && !readIn.arReady |=> readOut.arValid && $stable(readOut.arAddr))
        else $error("AR dropped or changed before arReady");

    awStable: assert property (@(posedge clock) disable iff (!reset)
        writeOut.awValid && !writeIn.awReady |=> writeOut.awValid &&
        $stable(writeOut.awAddr))
        else $error("AW dropped or changed before awReady");

    wStable: assert property (@(posedge clock) disable iff (!reset)
        writeOut.wValid && !writeIn.wReady |=> writeOut.wValid &&
        $stable(writeOut.wData) && $stable(writeOut.wStrb))
        else $error("W dropped or changed before wReady");

    // Everything quiet while reset is low
    resetQuiet: assert property (@(posedge clock)
        !reset |-> !readOut.arValid && !readOut.rReady && !writeOut.awValid &&
        !writeOut.wValid && !writeOut.bReady && (stageValid == 2'b00) && !done)
        else $error("Control output high during reset");

    doneHolds: assert property (@(posedge clock) disable iff (!reset)
        done |=> done)
        else $error("done fell before reset");
endmodule

bind cpu8Top cpu8Sva u_cpu8Sva (
    .clock      (clock),
    .reset      (reset),
    .readOut    (readOut),
    .readIn     (readIn),
    .writeOut   (writeOut),
    .writeIn    (writeIn),
    .stageValid ({stagedOpValid, stagedResValid}),
    .done       (done)
);
